// File: common/jtag_params.svh
/* Register map, memory size, version and TAP reset length of the JTAG master */
`ifndef JTAG_PARAMS_SVH
`define JTAG_PARAMS_SVH

`define JTAG_MEM_BYTES      16
`define JTAG_VERSION        1
`define JTAG_RESET_CYCLES   5

// Host byte addresses
`define JTAG_ADDR_RESET     0
`define JTAG_ADDR_START     1
`define JTAG_ADDR_BITS_LO   2
`define JTAG_ADDR_BITS_HI   3
`define JTAG_ADDR_WORDS_LO  4
`define JTAG_ADDR_WORDS_HI  5
`define JTAG_ADDR_OPCODE    6
`define JTAG_ADDR_OUT_MEM   16
`define JTAG_ADDR_IN_MEM    32

`endif

// File: common/jtag_pkg.sv
/* TAP state enum, op code, scan configuration and host bus types */
package jtag_pkg;

    typedef enum logic [3:0] {
        TEST_LOGIC_RESET,
        RUN_TEST_IDLE,
        SELECT_DR,
        CAPTURE_DR,
        SHIFT_DR,
        EXIT1_DR,
        PAUSE_DR,
        EXIT2_DR,
        UPDATE_DR,
        SELECT_IR,
        CAPTURE_IR,
        SHIFT_IR,
        EXIT1_IR,
        PAUSE_IR,
        EXIT2_IR,
        UPDATE_IR
    } tap_state_t;

    typedef enum logic {
        IR_SCAN = 1'b0,
        DR_SCAN = 1'b1
    } jtag_op_t;

    // Scan setup seen by the fsm and the counters
    typedef struct packed {
        logic [15:0] bit_count;
        logic [15:0] word_count;
        jtag_op_t    op;
    } jtag_cfg_t;

    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] wdata;
        logic       wr;
        logic       rd;
    } jtag_bus_t;

endpackage

// File: jtag_master/jtag_bit_mem.sv
/* Scan data memory with a host byte port and a serial bit port */
`timescale 1ns/1ps
`include "jtag_params.svh"

module jtag_bit_mem (
    input  logic       JTAG_CLK,
    input  logic       we,
    input  logic [3:0] byte_addr,
    input  logic [7:0] wbyte,
    output logic [7:0] rbyte,
    input  logic       bit_we,
    input  logic [6:0] bit_addr,
    input  logic       bit_in,
    output logic       bit_out
);

    logic [7:0] mem [`JTAG_MEM_BYTES];
    logic [3:0] bit_byte;
    logic [2:0] bit_pos;

    // Stream order is MSB of each byte first
    assign bit_byte = bit_addr[6:3];
    assign bit_pos  = 3'd7 - bit_addr[2:0];

    assign rbyte   = mem[byte_addr];
    assign bit_out = mem[bit_byte][bit_pos];

    always_ff @(posedge JTAG_CLK)
    begin
        if (we)
            mem[byte_addr] <= wbyte;
        if (bit_we)
            mem[bit_byte][bit_pos] <= bit_in;   // Serial side wins on a clash
    end

endmodule

// File: jtag_master/jtag_shift_counter.sv
/* Bit, word and TAP reset counters with their end flags */
`timescale 1ns/1ps
`include "jtag_params.svh"

module jtag_shift_counter (
    input  logic                 JTAG_CLK,
    input  logic                 RST_SYNC,
    input  jtag_pkg::tap_state_t state,
    input  jtag_pkg::jtag_cfg_t  cfg,
    output logic [15:0]          bit_cnt,
    output logic                 last_bit,
    output logic                 all_words,
    output logic                 reset_done
);

    logic [15:0] word_cnt;
    logic [3:0]  reset_cnt;
    logic        shifting;

    assign shifting   = state == jtag_pkg::SHIFT_DR || state == jtag_pkg::SHIFT_IR;
    assign last_bit   = bit_cnt == cfg.bit_count - 16'd1;
    assign all_words  = word_cnt == cfg.word_count;
    assign reset_done = state == jtag_pkg::TEST_LOGIC_RESET &&
                        reset_cnt == 4'(`JTAG_RESET_CYCLES - 1);

    always_ff @(posedge JTAG_CLK)
    begin
        if (RST_SYNC)
        begin
            bit_cnt   <= 16'd0;
            word_cnt  <= 16'd0;
            reset_cnt <= 4'd0;
        end
        else
        begin
            bit_cnt <= shifting ? bit_cnt + 16'd1 : 16'd0;

            if (state == jtag_pkg::UPDATE_DR || state == jtag_pkg::UPDATE_IR)
                word_cnt <= word_cnt + 16'd1;
            else if (state == jtag_pkg::RUN_TEST_IDLE && all_words)
                word_cnt <= 16'd0;   // Transfer complete

            if (state == jtag_pkg::TEST_LOGIC_RESET)
                reset_cnt <= reset_cnt + 4'd1;
            else
                reset_cnt <= 4'd0;
        end
    end

endmodule

// File: jtag_master/jtag_tap_fsm.sv
/* TAP controller FSM generating tms, tdi, sen, sld and the capture enable */
`timescale 1ns/1ps

module jtag_tap_fsm (
    input  logic                 JTAG_CLK,
    input  logic                 RST_SYNC,
    input  logic                 start,
    input  jtag_pkg::jtag_cfg_t  cfg,
    input  logic                 last_bit,
    input  logic                 all_words,
    input  logic                 reset_done,
    input  logic                 out_bit,
    output jtag_pkg::tap_state_t state,
    output logic                 tms,
    output logic                 tdi,
    output logic                 sen,
    output logic                 sld,
    output logic                 cap_en,
    output logic                 done
);

    jtag_pkg::tap_state_t next_state;
    logic                 tms_next;
    logic                 busy;
    logic [1:0]           sen_hist;
    logic                 in_shift_next;

    assign done          = busy && all_words && state == jtag_pkg::RUN_TEST_IDLE;
    assign in_shift_next = next_state == jtag_pkg::SHIFT_DR || next_state == jtag_pkg::SHIFT_IR;
    assign tdi           = out_bit & sen;
    assign cap_en        = sen_hist[0];   // tdo arrives one cycle behind tdi

    always_comb
    begin
        next_state = state;
        case (state)
            jtag_pkg::TEST_LOGIC_RESET:
                if (reset_done)
                    next_state = jtag_pkg::RUN_TEST_IDLE;
            jtag_pkg::RUN_TEST_IDLE:
                if (start || (busy && !all_words))
                    next_state = jtag_pkg::SELECT_DR;
            jtag_pkg::SELECT_DR:
                next_state = (cfg.op == jtag_pkg::DR_SCAN) ? jtag_pkg::CAPTURE_DR
                                                           : jtag_pkg::SELECT_IR;
            jtag_pkg::CAPTURE_DR: next_state = jtag_pkg::SHIFT_DR;
            jtag_pkg::SHIFT_DR:
                if (last_bit)
                    next_state = jtag_pkg::EXIT1_DR;
            jtag_pkg::EXIT1_DR:   next_state = jtag_pkg::UPDATE_DR;
            jtag_pkg::PAUSE_DR:   next_state = jtag_pkg::EXIT2_DR;
            jtag_pkg::EXIT2_DR:   next_state = jtag_pkg::UPDATE_DR;
            jtag_pkg::UPDATE_DR:  next_state = jtag_pkg::RUN_TEST_IDLE;
            jtag_pkg::SELECT_IR:  next_state = jtag_pkg::CAPTURE_IR;
            jtag_pkg::CAPTURE_IR: next_state = jtag_pkg::SHIFT_IR;
            jtag_pkg::SHIFT_IR:
                if (last_bit)
                    next_state = jtag_pkg::EXIT1_IR;
            jtag_pkg::EXIT1_IR:   next_state = jtag_pkg::UPDATE_IR;
            jtag_pkg::PAUSE_IR:   next_state = jtag_pkg::EXIT2_IR;
            jtag_pkg::EXIT2_IR:   next_state = jtag_pkg::UPDATE_IR;
            jtag_pkg::UPDATE_IR:  next_state = jtag_pkg::RUN_TEST_IDLE;
            default:              next_state = jtag_pkg::TEST_LOGIC_RESET;
        endcase
    end

    // TMS level that takes the IEEE graph from state to next_state
    always_comb
    begin
        case (state)
            jtag_pkg::TEST_LOGIC_RESET: tms_next = next_state == jtag_pkg::TEST_LOGIC_RESET;
            jtag_pkg::RUN_TEST_IDLE:    tms_next = next_state != jtag_pkg::RUN_TEST_IDLE;
            jtag_pkg::SELECT_DR:        tms_next = next_state == jtag_pkg::SELECT_IR;
            jtag_pkg::SHIFT_DR:         tms_next = next_state == jtag_pkg::EXIT1_DR;
            jtag_pkg::SHIFT_IR:         tms_next = next_state == jtag_pkg::EXIT1_IR;
            jtag_pkg::EXIT1_DR, jtag_pkg::EXIT1_IR,
            jtag_pkg::PAUSE_DR, jtag_pkg::PAUSE_IR,
            jtag_pkg::EXIT2_DR, jtag_pkg::EXIT2_IR:
                tms_next = 1'b1;
            default:                    tms_next = 1'b0;   // Capture, select IR, update
        endcase
    end

    always_ff @(posedge JTAG_CLK)
    begin
        if (RST_SYNC)
        begin
            state    <= jtag_pkg::TEST_LOGIC_RESET;
            tms      <= 1'b1;
            sen      <= 1'b0;
            sen_hist <= 2'b00;
            sld      <= 1'b0;
            busy     <= 1'b0;
        end
        else
        begin
            state    <= next_state;
            tms      <= tms_next;
            sen      <= in_shift_next;
            sen_hist <= {sen_hist[0], sen};
            sld      <= sen_hist[1] && !sen_hist[0];   // Two cycles after the last shift bit
            if (start)
                busy <= 1'b1;
            else if (done)
                busy <= 1'b0;
        end
    end

    a_tms_low_in_shift: assert property (@(posedge JTAG_CLK) disable iff (RST_SYNC)
        (state == jtag_pkg::SHIFT_DR && !last_bit) |-> !tms);

endmodule

// File: hw/jtag_regs.sv
/* Host register file with soft reset and start strobes, done flag and read mux */
`timescale 1ns/1ps
`include "jtag_params.svh"

module jtag_regs (
    input  logic                JTAG_CLK,
    input  logic                RST_SYNC,
    input  jtag_pkg::jtag_bus_t bus,
    input  logic                done,
    output logic [7:0]          rdata,
    output jtag_pkg::jtag_cfg_t cfg,
    output logic                local_rst,
    output logic                start,
    output logic                out_we,
    output logic                in_rd,
    output logic [3:0]          mem_byte_addr,
    input  logic [7:0]          out_rbyte,
    input  logic [7:0]          in_rbyte
);

    logic soft_rst;
    logic done_flag;
    logic in_out_range;
    logic in_in_range;

    assign in_out_range = bus.addr >= 8'(`JTAG_ADDR_OUT_MEM) &&
                          bus.addr < 8'(`JTAG_ADDR_OUT_MEM + `JTAG_MEM_BYTES);
    assign in_in_range  = bus.addr >= 8'(`JTAG_ADDR_IN_MEM) &&
                          bus.addr < 8'(`JTAG_ADDR_IN_MEM + `JTAG_MEM_BYTES);

    assign out_we        = bus.wr && in_out_range;
    assign in_rd         = bus.wr && in_in_range;   // Host write into capture memory
    assign mem_byte_addr = bus.addr[3:0];
    assign local_rst     = RST_SYNC || soft_rst;

    // Strobes from writes to the command addresses
    always_ff @(posedge JTAG_CLK)
    begin
        if (RST_SYNC)
        begin
            soft_rst <= 1'b0;
            start    <= 1'b0;
        end
        else
        begin
            soft_rst <= bus.wr && bus.addr == 8'(`JTAG_ADDR_RESET);
            start    <= bus.wr && bus.addr == 8'(`JTAG_ADDR_START) && !soft_rst;
        end
    end

    always_ff @(posedge JTAG_CLK)
    begin
        if (local_rst)
        begin
            cfg.bit_count  <= 16'(8 * `JTAG_MEM_BYTES);
            cfg.word_count <= 16'd1;
            cfg.op         <= jtag_pkg::IR_SCAN;
        end
        else if (bus.wr)
        begin
            case (bus.addr)
                8'(`JTAG_ADDR_BITS_LO):  cfg.bit_count[7:0]   <= bus.wdata;
                8'(`JTAG_ADDR_BITS_HI):  cfg.bit_count[15:8]  <= bus.wdata;
                8'(`JTAG_ADDR_WORDS_LO): cfg.word_count[7:0]  <= bus.wdata;
                8'(`JTAG_ADDR_WORDS_HI): cfg.word_count[15:8] <= bus.wdata;
                8'(`JTAG_ADDR_OPCODE):   cfg.op <= jtag_pkg::jtag_op_t'(bus.wdata[0]);
                default: ;
            endcase
        end
    end

    always_ff @(posedge JTAG_CLK)
    begin
        if (local_rst)
            done_flag <= 1'b1;
        else if (start)
            done_flag <= 1'b0;   // Start wins over a stale done
        else if (done)
            done_flag <= 1'b1;
    end

    // Read data valid the cycle after rd
    always_ff @(posedge JTAG_CLK)
    begin
        if (bus.rd)
        begin
            if (in_out_range)
                rdata <= out_rbyte;
            else if (in_in_range)
                rdata <= in_rbyte;
            else
            begin
                case (bus.addr)
                    8'(`JTAG_ADDR_RESET):    rdata <= 8'(`JTAG_VERSION);
                    8'(`JTAG_ADDR_START):    rdata <= {7'd0, done_flag};
                    8'(`JTAG_ADDR_BITS_LO):  rdata <= cfg.bit_count[7:0];
                    8'(`JTAG_ADDR_BITS_HI):  rdata <= cfg.bit_count[15:8];
                    8'(`JTAG_ADDR_WORDS_LO): rdata <= cfg.word_count[7:0];
                    8'(`JTAG_ADDR_WORDS_HI): rdata <= cfg.word_count[15:8];
                    8'(`JTAG_ADDR_OPCODE):   rdata <= {7'd0, cfg.op};
                    default:                 rdata <= 8'd0;
                endcase
            end
        end
    end

    a_start_not_in_reset: assert property (@(posedge JTAG_CLK) !(start && local_rst));

endmodule

// File: hw/jtag_master_top.sv
/* JTAG master top level with registers, TAP FSM, counters and scan memories */
`timescale 1ns/1ps

module jtag_master_top (
    input  logic                JTAG_CLK,
    input  logic                RST_SYNC,
    input  jtag_pkg::jtag_bus_t bus,
    output logic [7:0]          rdata,
    input  logic                tdo,
    output logic                tck,
    output logic                tms,
    output logic                tdi,
    output logic                sen,
    output logic                sld
);

    jtag_pkg::jtag_cfg_t  cfg;
    jtag_pkg::tap_state_t state;
    logic        local_rst;
    logic        start;
    logic        done;
    logic        out_we;
    logic        in_rd;
    logic [3:0]  mem_byte_addr;
    logic [7:0]  out_rbyte;
    logic [7:0]  in_rbyte;
    logic [15:0] bit_cnt;
    logic [15:0] cap_idx;
    logic        last_bit;
    logic        all_words;
    logic        reset_done;
    logic        out_bit;
    logic        cap_en;

    assign tck     = JTAG_CLK;
    assign cap_idx = bit_cnt - 16'd1;   // Capture lags the shift by one bit

    jtag_regs u_regs (
        .JTAG_CLK(JTAG_CLK), .RST_SYNC(RST_SYNC), .bus(bus), .done(done),
        .rdata(rdata), .cfg(cfg), .local_rst(local_rst), .start(start),
        .out_we(out_we), .in_rd(in_rd), .mem_byte_addr(mem_byte_addr),
        .out_rbyte(out_rbyte), .in_rbyte(in_rbyte)
    );

    jtag_tap_fsm u_fsm (
        .JTAG_CLK(JTAG_CLK), .RST_SYNC(local_rst), .start(start), .cfg(cfg),
        .last_bit(last_bit), .all_words(all_words), .reset_done(reset_done),
        .out_bit(out_bit), .state(state), .tms(tms), .tdi(tdi), .sen(sen),
        .sld(sld), .cap_en(cap_en), .done(done)
    );

    jtag_shift_counter u_cnt (
        .JTAG_CLK(JTAG_CLK), .RST_SYNC(local_rst), .state(state), .cfg(cfg),
        .bit_cnt(bit_cnt), .last_bit(last_bit), .all_words(all_words),
        .reset_done(reset_done)
    );

    jtag_bit_mem out_mem (
        .JTAG_CLK(JTAG_CLK), .we(out_we), .byte_addr(mem_byte_addr),
        .wbyte(bus.wdata), .rbyte(out_rbyte), .bit_we(1'b0),
        .bit_addr(bit_cnt[6:0]), .bit_in(1'b0), .bit_out(out_bit)
    );

    jtag_bit_mem in_mem (
        .JTAG_CLK(JTAG_CLK), .we(in_rd), .byte_addr(mem_byte_addr),
        .wbyte(bus.wdata), .rbyte(in_rbyte), .bit_we(cap_en),
        .bit_addr(cap_idx[6:0]), .bit_in(tdo), .bit_out()
    );

endmodule

// File: testbench/jtag_master_tests.svh
/* Directed tests for the JTAG master, with bus access helpers,
   trace comparison and the LCG */

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

task automatic report_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    error_count++;
    $display("CHECK FAILED %s: expected 0x%0h, got 0x%0h", name, expected, got);
endtask

task automatic note_failure(input string what);
    error_count++;
    $display("ERROR: %s", what);
endtask

task automatic write_bus(input logic [7:0] addr, input logic [7:0] data);
    @(posedge JTAG_CLK);
    bus.addr  <= addr;
    bus.wdata <= data;
    bus.wr    <= 1'b1;
    @(posedge JTAG_CLK);   // Write lands on this edge
    bus <= '0;
endtask

task automatic read_bus(input logic [7:0] addr, output logic [7:0] data);
    @(posedge JTAG_CLK);
    bus.addr <= addr;
    bus.rd   <= 1'b1;
    @(posedge JTAG_CLK);
    bus <= '0;
    @(negedge JTAG_CLK);   // One cycle after rd
    data = rdata;
endtask

task automatic expect_read(input logic [7:0] addr, input logic [7:0] expected,
                           input string name);
    logic [7:0] got;
    read_bus(addr, got);
    if (got !== expected)
        report_mismatch(name, got, expected);
endtask

task automatic configure_scan(input logic [15:0] bits, input logic [15:0] words,
                              input jtag_pkg::jtag_op_t op);
    write_bus(`JTAG_ADDR_BITS_LO, bits[7:0]);
    write_bus(`JTAG_ADDR_BITS_HI, bits[15:8]);
    write_bus(`JTAG_ADDR_WORDS_LO, words[7:0]);
    write_bus(`JTAG_ADDR_WORDS_HI, words[15:8]);
    write_bus(`JTAG_ADDR_OPCODE, {7'd0, op});
endtask

task automatic load_out_mem();
    logic [31:0] value;
    int          i;
    for (i = 0; i < `JTAG_MEM_BYTES; i++)
    begin
        value = lcg_next();
        out_model[i] = value[23:16];
        write_bus(8'(`JTAG_ADDR_OUT_MEM + i), out_model[i]);
    end
endtask

function automatic logic stream_bit(input int k);
    return out_model[k / 8][7 - (k % 8)];   // MSB of byte 0 first
endfunction

// TAP reset seen from the edge that applies it
task automatic watch_tap_reset();
    int i;
    for (i = 0; i < `JTAG_RESET_CYCLES; i++)
    begin
        @(negedge JTAG_CLK);
        if ({tms, sen, tdi, sld} !== 4'b1000)
            report_mismatch("tms_sen_tdi_sld in reset", {tms, sen, tdi, sld}, 4'b1000);
    end
    @(negedge JTAG_CLK);
    if (tms !== 1'b0)
        report_mismatch("tms after reset", tms, 1'b0);
endtask

// tck sampled a quarter period into each clock phase
task automatic check_tck_follows_clock();
    int i;
    for (i = 0; i < 4; i++)
    begin
        @(posedge JTAG_CLK);
        #(CLK_HALF / 2);
        if (tck !== 1'b1)
            report_mismatch("tck high phase", tck, 1'b1);
        @(negedge JTAG_CLK);
        #(CLK_HALF / 2);
        if (tck !== 1'b0)
            report_mismatch("tck low phase", tck, 1'b0);
    end
endtask

task automatic start_and_wait();
    logic [7:0] status;
    int         polls;
    trace.delete();
    trace_on = 1'b1;
    write_bus(`JTAG_ADDR_START, 8'h01);
    status = 8'h00;
    polls  = 0;
    while (status[0] !== 1'b1 && polls < 1000)
    begin
        read_bus(`JTAG_ADDR_START, status);
        polls++;
    end
    if (status[0] !== 1'b1)
        note_failure("done flag never came back after start");
    repeat (2) @(negedge JTAG_CLK);
    trace_on = 1'b0;
endtask

// Pin trace against the IEEE TAP path, one word after the other
task automatic compare_trace(input int bits, input int words, input jtag_pkg::jtag_op_t op);
    int first;
    int pos;
    int lead;
    int w;
    int k;
    logic [3:0] expected [$];
    lead  = (op == jtag_pkg::DR_SCAN) ? 1 : 2;
    first = -1;
    for (pos = 0; pos < trace.size() && first < 0; pos++)
    begin
        if (trace[pos][3])
            first = pos;
    end
    for (w = 0; w < words; w++)
    begin
        for (k = 0; k < lead; k++)
            expected.push_back(4'b1000);   // Select states
        expected.push_back(4'b0000);       // Capture
        for (k = 0; k < bits; k++)
            expected.push_back({2'b01, stream_bit(k), 1'b0});
        expected.push_back(4'b1000);       // Exit1
        expected.push_back(4'b1000);       // Update
        expected.push_back(4'b0001);       // Idle with load pulse
    end
    if (first < 0 || first + expected.size() > trace.size())
    begin
        note_failure("scan pattern missing or cut short in the pin trace");
        return;
    end
    for (pos = 0; pos < trace.size() - first; pos++)
    begin
        if (pos < expected.size() && trace[first + pos] !== expected[pos])
            report_mismatch($sformatf("tms_sen_tdi_sld[%0d]", pos), trace[first + pos],
                            expected[pos]);
        else if (pos >= expected.size() && trace[first + pos] !== 4'b0000)
            report_mismatch($sformatf("tms_sen_tdi_sld[%0d]", pos), trace[first + pos],
                            4'b0000);
    end
endtask

task automatic check_reset_defaults();
    watch_tap_reset();
    expect_read(`JTAG_ADDR_RESET, 8'(`JTAG_VERSION), "version");
    expect_read(`JTAG_ADDR_START, 8'h01, "done");
    expect_read(`JTAG_ADDR_BITS_LO, 8'h80, "bits_lo");
    expect_read(`JTAG_ADDR_BITS_HI, 8'h00, "bits_hi");
    expect_read(`JTAG_ADDR_WORDS_LO, 8'h01, "words_lo");
    expect_read(`JTAG_ADDR_WORDS_HI, 8'h00, "words_hi");
    check_tck_follows_clock();
endtask

task automatic exercise_register_access();
    logic [31:0] value;
    logic [7:0]  got;
    int          addr;
    int          i;
    for (addr = `JTAG_ADDR_BITS_LO; addr <= `JTAG_ADDR_OPCODE; addr++)
    begin
        value = lcg_next();
        write_bus(8'(addr), value[15:8]);
        if (addr == `JTAG_ADDR_OPCODE)
            expect_read(8'(addr), {7'd0, value[8]}, "opcode");
        else
            expect_read(8'(addr), value[15:8], $sformatf("config reg %0d", addr));
    end
    load_out_mem();
    for (i = 0; i < `JTAG_MEM_BYTES; i++)
        expect_read(8'(`JTAG_ADDR_OUT_MEM + i), out_model[i], $sformatf("out_mem[%0d]", i));
    read_bus(8'(`JTAG_ADDR_OUT_MEM + 3), got);
    if (got !== out_model[3])
        report_mismatch("rdata", got, out_model[3]);
    @(negedge JTAG_CLK);
    if (rdata !== out_model[3])
        report_mismatch("rdata hold", rdata, out_model[3]);   // Held until the next read
endtask

task automatic run_dr_scan();
    configure_scan(16'd40, 16'd1, jtag_pkg::DR_SCAN);
    load_out_mem();
    start_and_wait();
    compare_trace(40, 1, jtag_pkg::DR_SCAN);
endtask

task automatic verify_loopback_capture();
    int i;
    configure_scan(16'd128, 16'd1, jtag_pkg::DR_SCAN);
    load_out_mem();
    start_and_wait();
    compare_trace(128, 1, jtag_pkg::DR_SCAN);
    for (i = 0; i < `JTAG_MEM_BYTES; i++)
        expect_read(8'(`JTAG_ADDR_IN_MEM + i), out_model[i], $sformatf("in_mem[%0d]", i));
endtask

task automatic run_ir_multi_word();
    configure_scan(16'd16, 16'd3, jtag_pkg::IR_SCAN);
    start_and_wait();
    compare_trace(16, 3, jtag_pkg::IR_SCAN);
endtask

task automatic apply_soft_reset_mid_scan();
    int waits;
    configure_scan(16'h0120, 16'h0203, jtag_pkg::DR_SCAN);   // Every byte off its default
    write_bus(`JTAG_ADDR_START, 8'h01);
    waits = 0;
    while (sen !== 1'b1 && waits < 50)
    begin
        @(negedge JTAG_CLK);
        waits++;
    end
    if (sen !== 1'b1)
        note_failure("shift never began before the soft reset");
    repeat (10) @(posedge JTAG_CLK);
    write_bus(`JTAG_ADDR_RESET, 8'h00);
    @(posedge JTAG_CLK);   // Local reset applied here
    watch_tap_reset();
    expect_read(`JTAG_ADDR_START, 8'h01, "done after soft reset");
    expect_read(`JTAG_ADDR_BITS_LO, 8'h80, "bits_lo after soft reset");
    expect_read(`JTAG_ADDR_BITS_HI, 8'h00, "bits_hi after soft reset");
    expect_read(`JTAG_ADDR_WORDS_LO, 8'h01, "words_lo after soft reset");
    expect_read(`JTAG_ADDR_WORDS_HI, 8'h00, "words_hi after soft reset");
    expect_read(`JTAG_ADDR_OPCODE, 8'h00, "opcode after soft reset");
endtask

// File: testbench/jtag_master_tb.sv
/* Testbench for the JTAG master
   Clock, reset, tdo loopback, pin trace, timeout and result summary */
`timescale 1ns/1ps
`include "jtag_params.svh"

module jtag_master_tb;

    localparam int CLK_HALF       = 4;
    localparam int RESET_CYCLES   = 5;
    localparam int TIMEOUT_CYCLES = 20000;

    logic                JTAG_CLK;
    logic                RST_SYNC;
    jtag_pkg::jtag_bus_t bus;
    logic [7:0]          rdata;
    logic                tdo = 1'b0;
    logic                tck;
    logic                tms;
    logic                tdi;
    logic                sen;
    logic                sld;

    int          error_count;
    int          cycle_count = 0;
    logic [31:0] lcg_state;
    logic [7:0]  out_model [`JTAG_MEM_BYTES];   // Bytes written to the outgoing memory
    logic        trace_on;
    logic [3:0]  trace [$];                     // {tms, sen, tdi, sld} per cycle

    jtag_master_top UUT (
        .JTAG_CLK(JTAG_CLK),
        .RST_SYNC(RST_SYNC),
        .bus(bus),
        .rdata(rdata),
        .tdo(tdo),
        .tck(tck),
        .tms(tms),
        .tdi(tdi),
        .sen(sen),
        .sld(sld)
    );

    always #CLK_HALF JTAG_CLK = ~JTAG_CLK;

    // Scan target is a single flop from tdi to tdo
    always @(posedge JTAG_CLK)
        tdo <= tdi;

    // Pins sampled mid-cycle
    always @(negedge JTAG_CLK)
    begin
        if (trace_on)
            trace.push_back({tms, sen, tdi, sld});
    end

    always @(posedge JTAG_CLK)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run stopped after %0d cycles with %0d errors",
                     cycle_count, error_count);
            $display("test failed");
            $finish;
        end
    end

    `include "jtag_master_tests.svh"

    initial
    begin
        JTAG_CLK    = 1'b0;
        RST_SYNC    = 1'b1;
        bus         = '0;
        error_count = 0;
        lcg_state   = 32'hc776_018c;
        trace_on    = 1'b0;

        repeat (RESET_CYCLES) @(posedge JTAG_CLK);
        RST_SYNC <= 1'b0;

        check_reset_defaults();
        exercise_register_access();
        run_dr_scan();
        verify_loopback_capture();
        run_ir_multi_word();
        apply_soft_reset_mid_scan();

        $display("Run complete: %0d errors in %0d cycles", error_count, cycle_count);
        if (error_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// File: project.f
+incdir+common
+incdir+testbench
common/jtag_pkg.sv
jtag_master/jtag_bit_mem.sv
jtag_master/jtag_shift_counter.sv
jtag_master/jtag_tap_fsm.sv
hw/jtag_regs.sv
hw/jtag_master_top.sv
testbench/jtag_master_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the JTAG master testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
    --top-module jtag_master_tb -o jtag_master_sim > build.log 2>&1 \
    && ./obj_dir/jtag_master_sim > sim.log 2>&1 \
    || echo "Build or simulation error, see build.log and sim.log"

[ -f sim.log ] && cat sim.log
grep -qx "test passed" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }
